// ==== bus_pkg.sv ====
// AXI-lite response code and channel payload structs
`default_nettype none

package bus_pkg;

    // only the two codes the SRAM produces
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // read address channel
    typedef struct packed {
        logic [31:0] addr;
    } axi_ar_t;

    // read data channel
    typedef struct packed {
        logic [31:0] data;
        axi_resp_e   resp;
    } axi_r_t;

    // write address channel
    typedef struct packed {
        logic [31:0] addr;
    } axi_aw_t;

    // write data channel, one strobe bit per byte lane
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axi_w_t;

    // write response channel
    typedef struct packed {
        axi_resp_e resp;
    } axi_b_t;

endpackage

`default_nettype wire

// ==== core_pkg.sv ====
// core-side request/result structs, load/store opcode and unit state enums
`default_nettype none

package core_pkg;

    typedef enum logic {
        LOAD  = 1'b0,
        STORE = 1'b1
    } lsu_op_e;

    typedef struct packed {
        lsu_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
    } lsu_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } lsu_rsp_t;

    typedef enum logic {
        FETCH_IDLE,
        FETCH_BUSY
    } fetch_state_e;

    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_ADDR,
        LSU_WAIT_R,
        LSU_WAIT_B
    } lsu_state_e;

endpackage

`default_nettype wire

// ==== ifu_fetch.sv ====
// instruction fetch master that reads a word over AXI-lite whenever the pc moves
`timescale 1ns/1ps
`default_nettype none

module ifu_fetch #(
    parameter logic [31:0] PC_RESET = 32'h0000_0000
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic [31:0]      pc,
    output logic [31:0]           inst,
    output logic                  inst_valid,
    output logic                  ar_valid,
    output bus_pkg::axi_ar_t      ar,
    input  wire logic             ar_ready,
    input  wire logic             r_valid,
    input  wire bus_pkg::axi_r_t  r,
    output logic                  r_ready
);

    core_pkg::fetch_state_e state;
    logic [31:0]            last_pc;
    logic                   fetch_due;
    logic                   idle;
    logic                   pc_change;

    assign idle      = (state == core_pkg::FETCH_IDLE);
    assign pc_change = (pc != last_pc);

    // a read is owed after reset and while an address waits for its grant
    assign ar_valid   = idle & (pc_change | fetch_due);
    assign ar.addr    = pc;
    assign r_ready    = (state == core_pkg::FETCH_BUSY);
    assign inst_valid = idle & ~pc_change & ~fetch_due;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= core_pkg::FETCH_IDLE;
            last_pc   <= PC_RESET;
            fetch_due <= 1'b1;
        end else begin
            if (idle && pc_change) begin
                last_pc <= pc;
            end
            case (state)
                core_pkg::FETCH_IDLE: begin
                    if (ar_valid && ar_ready) begin
                        state     <= core_pkg::FETCH_BUSY;
                        fetch_due <= 1'b0;
                    end else if (pc_change) begin
                        fetch_due <= 1'b1;
                    end
                end
                core_pkg::FETCH_BUSY: begin
                    // stale data still lands and the pc compare hides it
                    if (r_valid) begin
                        state <= core_pkg::FETCH_IDLE;
                    end
                end
                default: state <= core_pkg::FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (r_valid && r_ready) begin
            inst <= r.data;
        end
    end

endmodule

`default_nettype wire

// ==== lsu_access.sv ====
// load/store master turning one core request into one AXI-lite read or write
`timescale 1ns/1ps
`default_nettype none

module lsu_access (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               req_valid,
    output logic                    req_ready,
    input  wire core_pkg::lsu_req_t req,
    output logic                    rsp_valid,
    output core_pkg::lsu_rsp_t      rsp,
    output logic                    ar_valid,
    output bus_pkg::axi_ar_t        ar,
    input  wire logic               ar_ready,
    input  wire logic               r_valid,
    input  wire bus_pkg::axi_r_t    r,
    output logic                    r_ready,
    output logic                    aw_valid,
    output bus_pkg::axi_aw_t        aw,
    input  wire logic               aw_ready,
    output logic                    w_valid,
    output bus_pkg::axi_w_t         w,
    input  wire logic               w_ready,
    input  wire logic               b_valid,
    input  wire bus_pkg::axi_b_t    b,
    output logic                    b_ready
);

    core_pkg::lsu_state_e state;
    core_pkg::lsu_req_t   req_q;
    logic                 ar_pend;
    logic                 aw_pend;
    logic                 w_pend;
    logic                 aw_left;
    logic                 w_left;
    logic                 is_store;

    assign req_ready = (state == core_pkg::LSU_IDLE);
    assign is_store  = (req.op == core_pkg::STORE);

    assign ar_valid = ar_pend;
    assign ar.addr  = req_q.addr;
    assign aw_valid = aw_pend;
    assign aw.addr  = req_q.addr;
    assign w_valid  = w_pend;
    assign w.data   = req_q.wdata;
    assign w.strb   = req_q.strb;
    assign r_ready  = (state == core_pkg::LSU_WAIT_R);
    assign b_ready  = (state == core_pkg::LSU_WAIT_B);

    // write channels still owed after this cycle
    assign aw_left = aw_pend & ~aw_ready;
    assign w_left  = w_pend & ~w_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= core_pkg::LSU_IDLE;
            ar_pend   <= 1'b0;
            aw_pend   <= 1'b0;
            w_pend    <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                core_pkg::LSU_IDLE: begin
                    if (req_valid) begin
                        state   <= core_pkg::LSU_ADDR;
                        ar_pend <= ~is_store;
                        aw_pend <= is_store;
                        w_pend  <= is_store;
                    end
                end
                core_pkg::LSU_ADDR: begin
                    if (ar_pend) begin
                        if (ar_ready) begin
                            ar_pend <= 1'b0;
                            state   <= core_pkg::LSU_WAIT_R;
                        end
                    end else begin
                        // aw and w may be taken on different cycles
                        aw_pend <= aw_left;
                        w_pend  <= w_left;
                        if (!aw_left && !w_left) begin
                            state <= core_pkg::LSU_WAIT_B;
                        end
                    end
                end
                core_pkg::LSU_WAIT_R: begin
                    if (r_valid) begin
                        rsp_valid <= 1'b1;
                        state     <= core_pkg::LSU_IDLE;
                    end
                end
                core_pkg::LSU_WAIT_B: begin
                    if (b_valid) begin
                        rsp_valid <= 1'b1;
                        state     <= core_pkg::LSU_IDLE;
                    end
                end
                default: state <= core_pkg::LSU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
        if (r_valid && r_ready) begin
            rsp.rdata <= r.data;
            rsp.err   <= (r.resp == bus_pkg::SLVERR);
        end else if (b_valid && b_ready) begin
            rsp.rdata <= '0;
            rsp.err   <= (b.resp == bus_pkg::SLVERR);
        end
    end

endmodule

`default_nettype wire

// ==== axi_lite_arbiter.sv ====
// two-master AXI-lite arbiter with a round-robin grant held for a whole transaction
`timescale 1ns/1ps
`default_nettype none

module axi_lite_arbiter (
    input  wire logic             clk,
    input  wire logic             rst,
    // master 0 is the fetch unit
    input  wire logic             m0_ar_valid,
    input  wire bus_pkg::axi_ar_t m0_ar,
    output logic                  m0_ar_ready,
    output logic                  m0_r_valid,
    output bus_pkg::axi_r_t       m0_r,
    input  wire logic             m0_r_ready,
    input  wire logic             m0_aw_valid,
    input  wire bus_pkg::axi_aw_t m0_aw,
    output logic                  m0_aw_ready,
    input  wire logic             m0_w_valid,
    input  wire bus_pkg::axi_w_t  m0_w,
    output logic                  m0_w_ready,
    output logic                  m0_b_valid,
    output bus_pkg::axi_b_t       m0_b,
    input  wire logic             m0_b_ready,
    // master 1 is the load/store unit
    input  wire logic             m1_ar_valid,
    input  wire bus_pkg::axi_ar_t m1_ar,
    output logic                  m1_ar_ready,
    output logic                  m1_r_valid,
    output bus_pkg::axi_r_t       m1_r,
    input  wire logic             m1_r_ready,
    input  wire logic             m1_aw_valid,
    input  wire bus_pkg::axi_aw_t m1_aw,
    output logic                  m1_aw_ready,
    input  wire logic             m1_w_valid,
    input  wire bus_pkg::axi_w_t  m1_w,
    output logic                  m1_w_ready,
    output logic                  m1_b_valid,
    output bus_pkg::axi_b_t       m1_b,
    input  wire logic             m1_b_ready,
    // slave side toward the SRAM
    output logic                  s_ar_valid,
    output bus_pkg::axi_ar_t      s_ar,
    input  wire logic             s_ar_ready,
    input  wire logic             s_r_valid,
    input  wire bus_pkg::axi_r_t  s_r,
    output logic                  s_r_ready,
    output logic                  s_aw_valid,
    output bus_pkg::axi_aw_t      s_aw,
    input  wire logic             s_aw_ready,
    output logic                  s_w_valid,
    output bus_pkg::axi_w_t       s_w,
    input  wire logic             s_w_ready,
    input  wire logic             s_b_valid,
    input  wire bus_pkg::axi_b_t  s_b,
    output logic                  s_b_ready
);

    logic grant;
    logic busy;
    logic last_win;
    logic req0;
    logic req1;
    logic pick;
    logic sel;
    logic done;

    assign req0 = m0_ar_valid | m0_aw_valid;
    assign req1 = m1_ar_valid | m1_aw_valid;
    // on a tie the master that did not win last goes first
    assign pick = (req0 & req1) ? ~last_win : req1;
    assign sel  = busy ? grant : pick;
    assign done = (s_r_valid & s_r_ready) | (s_b_valid & s_b_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            grant    <= 1'b0;
            last_win <= 1'b1;
        end else if (!busy) begin
            if (req0 || req1) begin
                busy  <= 1'b1;
                grant <= pick;
            end
        end else if (done) begin
            busy     <= 1'b0;
            last_win <= grant;
        end
    end

    // request channels from the selected master
    assign s_ar_valid = sel ? m1_ar_valid : m0_ar_valid;
    assign s_ar       = sel ? m1_ar : m0_ar;
    assign s_aw_valid = sel ? m1_aw_valid : m0_aw_valid;
    assign s_aw       = sel ? m1_aw : m0_aw;
    assign s_w_valid  = sel ? m1_w_valid : m0_w_valid;
    assign s_w        = sel ? m1_w : m0_w;
    assign s_r_ready  = sel ? m1_r_ready : m0_r_ready;
    assign s_b_ready  = sel ? m1_b_ready : m0_b_ready;

    // the other master sees ready low and holds its request
    assign m0_ar_ready = ~sel & s_ar_ready;
    assign m1_ar_ready = sel & s_ar_ready;
    assign m0_aw_ready = ~sel & s_aw_ready;
    assign m1_aw_ready = sel & s_aw_ready;
    assign m0_w_ready  = ~sel & s_w_ready;
    assign m1_w_ready  = sel & s_w_ready;

    assign m0_r_valid = ~sel & s_r_valid;
    assign m1_r_valid = sel & s_r_valid;
    assign m0_b_valid = ~sel & s_b_valid;
    assign m1_b_valid = sel & s_b_valid;
    assign m0_r       = s_r;
    assign m1_r       = s_r;
    assign m0_b       = s_b;
    assign m1_b       = s_b;

endmodule

`default_nettype wire

// ==== axi_lite_sram.sv ====
// AXI-lite slave around a word array with byte strobes and out-of-range SLVERR
`timescale 1ns/1ps
`default_nettype none

module axi_lite_sram #(
    parameter int MEM_WORDS = 1024
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             s_ar_valid,
    input  wire bus_pkg::axi_ar_t s_ar,
    output logic                  s_ar_ready,
    output logic                  s_r_valid,
    output bus_pkg::axi_r_t       s_r,
    input  wire logic             s_r_ready,
    input  wire logic             s_aw_valid,
    input  wire bus_pkg::axi_aw_t s_aw,
    output logic                  s_aw_ready,
    input  wire logic             s_w_valid,
    input  wire bus_pkg::axi_w_t  s_w,
    output logic                  s_w_ready,
    output logic                  s_b_valid,
    output bus_pkg::axi_b_t       s_b,
    input  wire logic             s_b_ready
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [31:0] mem [MEM_WORDS];
    logic        resp_pend;
    logic        ar_hs;
    logic        wr_hs;
    logic [29:0] ar_word;
    logic [29:0] aw_word;
    logic        ar_ok;
    logic        aw_ok;

    // one transaction at a time and reads win a same-cycle tie
    assign resp_pend  = s_r_valid | s_b_valid;
    assign s_ar_ready = ~resp_pend;
    assign s_aw_ready = ~resp_pend & ~s_ar_valid & s_w_valid;
    assign s_w_ready  = ~resp_pend & ~s_ar_valid & s_aw_valid;

    assign ar_hs = s_ar_valid & s_ar_ready;
    assign wr_hs = s_aw_valid & s_aw_ready;

    assign ar_word = s_ar.addr[31:2];
    assign aw_word = s_aw.addr[31:2];
    assign ar_ok   = ({2'b00, ar_word} < 32'(MEM_WORDS));
    assign aw_ok   = ({2'b00, aw_word} < 32'(MEM_WORDS));

    always_ff @(posedge clk) begin
        if (rst) begin
            s_r_valid <= 1'b0;
            s_b_valid <= 1'b0;
        end else begin
            if (ar_hs) begin
                s_r_valid <= 1'b1;
            end else if (s_r_ready) begin
                s_r_valid <= 1'b0;
            end
            if (wr_hs) begin
                s_b_valid <= 1'b1;
            end else if (s_b_ready) begin
                s_b_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            s_r.data <= ar_ok ? mem[ar_word[IDX_W-1:0]] : '0;
            s_r.resp <= ar_ok ? bus_pkg::OKAY : bus_pkg::SLVERR;
        end
        if (wr_hs) begin
            s_b.resp <= aw_ok ? bus_pkg::OKAY : bus_pkg::SLVERR;
        end
        // byte lanes merge into the stored word
        if (wr_hs && aw_ok) begin
            for (int i = 0; i < 4; i++) begin
                if (s_w.strb[i]) begin
                    mem[aw_word[IDX_W-1:0]][8*i +: 8] <= s_w.data[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== mem_subsystem_top.sv ====
// memory subsystem top with fetch and load/store masters sharing one SRAM
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top #(
    parameter logic [31:0] PC_RESET  = 32'h0000_0000,
    parameter int          MEM_WORDS = 1024
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic [31:0]        pc,
    output logic [31:0]             inst,
    output logic                    inst_valid,
    input  wire logic               req_valid,
    output logic                    req_ready,
    input  wire core_pkg::lsu_req_t req,
    output logic                    rsp_valid,
    output core_pkg::lsu_rsp_t      rsp
);

    // fetch read channels
    logic                if_ar_valid;
    bus_pkg::axi_ar_t    if_ar;
    logic                if_ar_ready;
    logic                if_r_valid;
    bus_pkg::axi_r_t     if_r;
    logic                if_r_ready;

    // load/store channels
    logic                ls_ar_valid;
    bus_pkg::axi_ar_t    ls_ar;
    logic                ls_ar_ready;
    logic                ls_r_valid;
    bus_pkg::axi_r_t     ls_r;
    logic                ls_r_ready;
    logic                ls_aw_valid;
    bus_pkg::axi_aw_t    ls_aw;
    logic                ls_aw_ready;
    logic                ls_w_valid;
    bus_pkg::axi_w_t     ls_w;
    logic                ls_w_ready;
    logic                ls_b_valid;
    bus_pkg::axi_b_t     ls_b;
    logic                ls_b_ready;

    // arbiter to SRAM
    logic                sr_ar_valid;
    bus_pkg::axi_ar_t    sr_ar;
    logic                sr_ar_ready;
    logic                sr_r_valid;
    bus_pkg::axi_r_t     sr_r;
    logic                sr_r_ready;
    logic                sr_aw_valid;
    bus_pkg::axi_aw_t    sr_aw;
    logic                sr_aw_ready;
    logic                sr_w_valid;
    bus_pkg::axi_w_t     sr_w;
    logic                sr_w_ready;
    logic                sr_b_valid;
    bus_pkg::axi_b_t     sr_b;
    logic                sr_b_ready;

    ifu_fetch #(
        .PC_RESET(PC_RESET)
    ) u_ifu (
        .clk(clk), .rst(rst), .pc(pc), .inst(inst), .inst_valid(inst_valid),
        .ar_valid(if_ar_valid), .ar(if_ar), .ar_ready(if_ar_ready),
        .r_valid(if_r_valid), .r(if_r), .r_ready(if_r_ready)
    );

    lsu_access u_lsu (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .rsp_valid(rsp_valid), .rsp(rsp),
        .ar_valid(ls_ar_valid), .ar(ls_ar), .ar_ready(ls_ar_ready),
        .r_valid(ls_r_valid), .r(ls_r), .r_ready(ls_r_ready),
        .aw_valid(ls_aw_valid), .aw(ls_aw), .aw_ready(ls_aw_ready),
        .w_valid(ls_w_valid), .w(ls_w), .w_ready(ls_w_ready),
        .b_valid(ls_b_valid), .b(ls_b), .b_ready(ls_b_ready)
    );

    // fetch never writes so its write side is tied off
    axi_lite_arbiter u_arb (
        .clk(clk), .rst(rst),
        .m0_ar_valid(if_ar_valid), .m0_ar(if_ar), .m0_ar_ready(if_ar_ready),
        .m0_r_valid(if_r_valid), .m0_r(if_r), .m0_r_ready(if_r_ready),
        .m0_aw_valid(1'b0), .m0_aw('0), .m0_aw_ready(),
        .m0_w_valid(1'b0), .m0_w('0), .m0_w_ready(),
        .m0_b_valid(), .m0_b(), .m0_b_ready(1'b0),
        .m1_ar_valid(ls_ar_valid), .m1_ar(ls_ar), .m1_ar_ready(ls_ar_ready),
        .m1_r_valid(ls_r_valid), .m1_r(ls_r), .m1_r_ready(ls_r_ready),
        .m1_aw_valid(ls_aw_valid), .m1_aw(ls_aw), .m1_aw_ready(ls_aw_ready),
        .m1_w_valid(ls_w_valid), .m1_w(ls_w), .m1_w_ready(ls_w_ready),
        .m1_b_valid(ls_b_valid), .m1_b(ls_b), .m1_b_ready(ls_b_ready),
        .s_ar_valid(sr_ar_valid), .s_ar(sr_ar), .s_ar_ready(sr_ar_ready),
        .s_r_valid(sr_r_valid), .s_r(sr_r), .s_r_ready(sr_r_ready),
        .s_aw_valid(sr_aw_valid), .s_aw(sr_aw), .s_aw_ready(sr_aw_ready),
        .s_w_valid(sr_w_valid), .s_w(sr_w), .s_w_ready(sr_w_ready),
        .s_b_valid(sr_b_valid), .s_b(sr_b), .s_b_ready(sr_b_ready)
    );

    axi_lite_sram #(
        .MEM_WORDS(MEM_WORDS)
    ) u_sram (
        .clk(clk), .rst(rst),
        .s_ar_valid(sr_ar_valid), .s_ar(sr_ar), .s_ar_ready(sr_ar_ready),
        .s_r_valid(sr_r_valid), .s_r(sr_r), .s_r_ready(sr_r_ready),
        .s_aw_valid(sr_aw_valid), .s_aw(sr_aw), .s_aw_ready(sr_aw_ready),
        .s_w_valid(sr_w_valid), .s_w(sr_w), .s_w_ready(sr_w_ready),
        .s_b_valid(sr_b_valid), .s_b(sr_b), .s_b_ready(sr_b_ready)
    );

endmodule

`default_nettype wire

// ==== tb_mem_subsystem.sv ====
// testbench for the memory subsystem that replays mem_stimulus.txt
// against a reference word model of the SRAM
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

    localparam int          MEM_WORDS = 256;
    localparam int          MAX_LINES = 64;
    localparam logic [31:0] SEED      = 32'hde99c93d;

    // one parsed line of the stimulus file
    typedef struct packed {
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic [31:0] exp_val;
        logic        exp_err;
    } stim_line_t;

    logic               clk;
    logic               rst;
    logic [31:0]        pc;
    logic [31:0]        inst;
    logic               inst_valid;
    logic               req_valid;
    logic               req_ready;
    core_pkg::lsu_req_t req;
    logic               rsp_valid;
    core_pkg::lsu_rsp_t rsp;

    stim_line_t  lines [MAX_LINES];
    // unwritten words stay x as in the SRAM
    logic [31:0] ref_mem [MEM_WORDS];
    int          n_lines;
    int          file_errors;
    int          cycle_count;
    int          cycle_limit;
    int          test_errs;
    int          tests_passed;
    int          tests_failed;

    mem_subsystem_top #(
        .MEM_WORDS(MEM_WORDS)
    ) u_dut (
        .clk(clk), .rst(rst), .pc(pc), .inst(inst), .inst_valid(inst_valid),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .rsp_valid(rsp_valid), .rsp(rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // watchdog whose limit is known once the file is read
    initial begin
        cycle_count = 0;
        do begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end while (cycle_count < cycle_limit);
        $display("timeout: a result did not arrive within %0d cycles", cycle_count);
        $display("Simulation failed");
        $finish;
    end

    task automatic load_stimulus();
        int          fd;
        int          code;
        int          ch;
        logic [7:0]  op;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [3:0]  f_strb;
        logic [31:0] f_exp;
        logic        f_err;
        logic        done;
        n_lines     = 0;
        file_errors = 0;
        fd = $fopen("mem_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open mem_stimulus.txt");
            file_errors = 1;
        end else begin
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, " %c", op);
                if (code != 1) begin
                    done = 1'b1;
                end else if (op == "#") begin
                    // comment runs to the end of the line
                    ch = $fgetc(fd);
                    while (ch != "\n" && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else begin
                    code = $fscanf(fd, " %h %h %h %h %h", f_addr, f_wdata, f_strb, f_exp, f_err);
                    if (code != 5 ||
                        !(op == "S" || op == "L" || op == "F" || op == "B")) begin
                        $display("stimulus entry %0d cannot be parsed", n_lines + 1);
                        file_errors = file_errors + 1;
                        done = 1'b1;
                    end else if (n_lines == MAX_LINES) begin
                        $display("stimulus file holds more than %0d entries", MAX_LINES);
                        file_errors = file_errors + 1;
                        done = 1'b1;
                    end else begin
                        lines[n_lines] = {op, f_addr, f_wdata, f_strb, f_exp, f_err};
                        n_lines = n_lines + 1;
                    end
                end
            end
            $fclose(fd);
            if (n_lines == 0) begin
                $display("stimulus file holds no operations");
                file_errors = file_errors + 1;
            end
        end
    endtask

    // strobed bytes replace the old ones and the rest are kept
    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = data[8*i +: 8];
            end
        end
        return res;
    endfunction

    // a word index at MEM_WORDS or above gives an error with zero data and no write
    task automatic predict(input stim_line_t ln, output logic [31:0] exp_val,
                           output logic exp_err);
        logic [29:0] word;
        word    = ln.addr[31:2];
        exp_err = (word >= MEM_WORDS);
        exp_val = '0;
        if (!exp_err) begin
            if (ln.op == "S") begin
                ref_mem[word] = merge_bytes(ref_mem[word], ln.wdata, ln.strb);
            end
            exp_val = ref_mem[word];
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Fail %0t ns: %s expected %h actual %h", $time, name, expected, actual);
            test_errs = test_errs + 1;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        assert (actual === expected) else begin
            $display("Fail %0t ns: %s expected %b actual %b", $time, name, expected, actual);
            test_errs = test_errs + 1;
        end
    endtask

    task automatic drive_request(input stim_line_t ln);
        req_valid <= 1'b1;
        req.op    <= (ln.op == "S") ? core_pkg::STORE : core_pkg::LOAD;
        req.addr  <= ln.addr;
        req.wdata <= ln.wdata;
        req.strb  <= ln.strb;
    endtask

    // handshake completes on the edge after req_ready is seen
    task automatic release_request();
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        req_valid <= 1'b0;
        // the unit stays busy once the request is taken
        @(negedge clk);
        check_bit("req_ready", 1'b0, req_ready);
    endtask

    task automatic run_line(input int n);
        stim_line_t         ln;
        logic [31:0]        exp_val;
        logic               exp_err;
        logic               pc_moved;
        logic               got_rsp;
        logic               got_inst;
        logic [31:0]        inst_q;
        core_pkg::lsu_rsp_t rsp_q;
        ln        = lines[n];
        test_errs = 0;
        predict(ln, exp_val, exp_err);
        assert (exp_val === ln.exp_val && exp_err === ln.exp_err) else begin
            $display("stimulus entry %0d disagrees with the model: file %h/%b, model %h/%b",
                     n + 1, ln.exp_val, ln.exp_err, exp_val, exp_err);
            test_errs = test_errs + 1;
        end
        pc_moved = (ln.addr != pc);
        @(posedge clk);
        if (ln.op == "F" || ln.op == "B") begin
            pc <= ln.addr;
        end
        if (ln.op != "F") begin
            drive_request(ln);
        end
        @(negedge clk);
        // a new pc hides the old instruction at once
        if (pc_moved && (ln.op == "F" || ln.op == "B")) begin
            check_bit("inst_valid", 1'b0, inst_valid);
        end
        if (ln.op != "F") begin
            release_request();
        end
        got_rsp  = (ln.op == "F");
        got_inst = (ln.op == "S" || ln.op == "L");
        while (!(got_rsp && got_inst)) begin
            @(negedge clk);
            if (!got_rsp && rsp_valid) begin
                got_rsp = 1'b1;
                rsp_q   = rsp;
            end
            if (!got_inst && inst_valid) begin
                got_inst = 1'b1;
                inst_q   = inst;
            end
        end
        // the response is a single-cycle pulse
        if (ln.op != "F") begin
            @(negedge clk);
            check_bit("rsp_valid", 1'b0, rsp_valid);
        end
        if (ln.op == "F" || ln.op == "B") begin
            check_word("inst", exp_val, inst_q);
        end
        if (ln.op == "L" || ln.op == "B" || exp_err) begin
            check_word("rsp.rdata", exp_val, rsp_q.rdata);
        end
        if (ln.op != "F") begin
            check_bit("rsp.err", exp_err, rsp_q.err);
        end
        $display("test %0d %c %h: %s", n + 1, ln.op, ln.addr,
                 (test_errs == 0) ? "ok" : "FAILED");
        if (test_errs == 0) begin
            tests_passed = tests_passed + 1;
        end else begin
            tests_failed = tests_failed + 1;
        end
        repeat ($urandom % 4) @(posedge clk);
    endtask

    initial begin
        rst          = 1'b1;
        pc           = '0;
        req_valid    = 1'b0;
        req          = '0;
        tests_passed = 0;
        tests_failed = 0;
        void'($urandom(SEED));
        load_stimulus();
        cycle_limit = 40 * n_lines + 100;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < n_lines; n++) begin
            run_line(n);
        end
        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && file_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_stimulus.txt ====
# op addr wdata strb expect err  (all hex, err 1 means an error response)
# op: S store, L load, F fetch, B fetch and load; expect is the word read, or the word after a store
S 00000010 11223344 f 11223344 0
L 00000010 00000000 0 11223344 0
S 00000014 aabbccdd f aabbccdd 0
S 00000014 00005500 2 aabb55dd 0
L 00000014 00000000 0 aabb55dd 0
S 00000018 01020304 f 01020304 0
S 00000018 f0e0d0c0 9 f00203c0 0
L 00000018 00000000 0 f00203c0 0
F 00000010 00000000 0 11223344 0
F 00000014 00000000 0 aabb55dd 0
S 00000020 deadbeef f deadbeef 0
F 00000020 00000000 0 deadbeef 0
B 00000018 00000000 0 f00203c0 0
S 00000100 cafef00d f cafef00d 0
B 00000100 00000000 0 cafef00d 0
S 00000000 0badc0de f 0badc0de 0
S 00000400 12345678 f 00000000 1
L 00000400 00000000 0 00000000 1
L 00000000 00000000 0 0badc0de 0
S 000003fc 89abcdef f 89abcdef 0
S 00000ffc 00000000 3 00000000 1
L 000003fc 00000000 0 89abcdef 0
F 000003fc 00000000 0 89abcdef 0
B 00000014 00000000 0 aabb55dd 0
S 00000010 0000ff00 2 1122ff44 0
F 00000010 00000000 0 1122ff44 0
L 00000010 00000000 0 1122ff44 0

// ==== all.f ====
bus_pkg.sv
core_pkg.sv
ifu_fetch.sv
lsu_access.sv
axi_lite_arbiter.sv
axi_lite_sram.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv
